//--- riscv_core.f
src/riscv_pkg.sv
src/riscv_ex_alu.sv
src/riscv_exu.sv
src/riscv_idu.sv
src/riscv_regfile.sv
src/riscv_pcu.sv
src/riscv_core.sv
tb/riscv_core_chk.sv
tb/riscv_core_tb.sv

//--- tb/riscv_core_tb.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_core_tb;
  import riscv_pkg::*;

  localparam int clk_period     = 20;
  localparam int seed           = 56361;
  localparam int timeout_margin = 50;
  localparam int alu_rounds     = 4;
  localparam int upper_rounds   = 4;
  localparam int branch_pairs   = 4;
  localparam int idle_cycles    = 5;
  // one cycle per issued word, plus reset and idle time.
  localparam int test_cycles = 6 + alu_rounds * 23 + upper_rounds * 2 + branch_pairs * 10
                               + 4 + 3 + idle_cycles;

  logic                      clk;
  logic                      rst_n;
  logic                      instr_valid;
  logic [data_width-1:0]     instr;
  logic [data_width-1:0]     pc;
  logic                      rd_wen;
  logic [reg_addr_width-1:0] rd_addr;
  logic [data_width-1:0]     rd_data;

  logic [31:0] mregs [0:31];  // model register file.
  logic [31:0] mpc;
  logic [15:0] lfsr;
  int          errors;
  int          cycles;

  riscv_core riscv_core_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rd_wen      (rd_wen),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  bind riscv_core riscv_core_chk riscv_core_chk_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .pc          (pc),
    .rd_wen      (rd_wen)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > test_cycles + timeout_margin) begin
      $display("timeout: the run did not finish within %0d cycles", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ####################################################################
  // instruction encoders and random source
  // ####################################################################

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // galois lfsr, one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // ####################################################################
  // reference model
  // ####################################################################

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt_sub,
                                          input logic alt_sra, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f3)
      3'd0: return alt_sub ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt_sra) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_step(input logic [31:0] ins, output logic wen,
                            output logic [31:0] res, output logic [31:0] npc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ii;
    logic [31:0] bi;
    logic [31:0] ji;
    logic        take;
    a    = mregs[ins[19:15]];
    b    = mregs[ins[24:20]];
    ii   = {{20{ins[31]}}, ins[31:20]};
    bi   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    ji   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    wen  = 1'b1;
    res  = '0;
    npc  = mpc + 32'd4;
    take = 1'b0;
    case (ins[6:0])
      op:     res = alu_ref(ins[14:12], ins[30], ins[30], a, b);
      op_imm: res = alu_ref(ins[14:12], 1'b0, ins[30], a, ii);
      lui:    res = {ins[31:12], 12'b0};
      auipc:  res = mpc + {ins[31:12], 12'b0};
      jal: begin
        res = mpc + 32'd4;
        npc = mpc + ji;
      end
      jalr: begin
        res = mpc + 32'd4;
        npc = (a + ii) & ~32'd1;
      end
      branch: begin
        wen = 1'b0;
        case (ins[14:12])
          3'd0:    take = (a == b);
          3'd1:    take = (a != b);
          3'd4:    take = $signed(a) < $signed(b);
          3'd5:    take = $signed(a) >= $signed(b);
          3'd6:    take = a < b;
          3'd7:    take = a >= b;
          default: take = 1'b0;
        endcase
        if (take) npc = mpc + bi;
      end
      default: wen = 1'b0;  // unknown words only step pc.
    endcase
  endtask

  // ####################################################################
  // drive and check
  // ####################################################################

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // entered on a falling edge; returns on the next one.
  task automatic issue(input logic [31:0] ins);
    logic        exp_wen;
    logic [31:0] exp_data;
    logic [31:0] exp_pc;
    model_step(ins, exp_wen, exp_data, exp_pc);
    instr       = ins;
    instr_valid = 1'b1;
    #1;
    check_value("rd_wen", 32'(exp_wen), 32'(rd_wen));
    if (exp_wen) begin
      check_value("rd_addr", 32'(ins[11:7]), 32'(rd_addr));
      check_value("rd_data", exp_data, rd_data);
    end
    @(posedge clk);
    if (exp_wen && ins[11:7] != 5'd0) mregs[ins[11:7]] = exp_data;
    mpc = exp_pc;
    @(negedge clk);
    instr_valid = 1'b0;
    check_value("pc", mpc, pc);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
    logic [19:0] upper;
    upper = val[31:12] + 20'(val[11]);  // addi sign-extends the low part.
    issue(u_type(upper, rd, lui));
    issue(i_type(val[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic test_reset_noop();
    check_value("pc", 32'd0, pc);
    check_value("rd_wen", 32'd0, 32'(rd_wen));
    issue(32'hffff_ffff);
    issue(32'h0000_0000);
  endtask

  task automatic test_alu_ops();
    logic [11:0] imm;
    for (int r = 0; r < alu_rounds; r++) begin
      load_reg(5'd1, rand_bits(32));
      load_reg(5'd2, rand_bits(32));
      for (int f = 0; f < 8; f++) begin
        issue(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
        if (f == 0 || f == 5) issue(r_type(7'h20, 5'd2, 5'd1, 3'(f), 5'd4));
        imm = 12'(rand_bits(12));
        if (f == 1 || f == 5) imm = {7'h00, imm[4:0]};
        issue(i_type(imm, 5'd1, 3'(f), 5'd5, op_imm));
        if (f == 5) issue(i_type({7'h20, imm[4:0]}, 5'd1, 3'(f), 5'd6, op_imm));
      end
    end
  endtask

  task automatic test_upper();
    for (int r = 0; r < upper_rounds; r++) begin
      issue(u_type(20'(rand_bits(20)), 5'd5, lui));
      issue(u_type(20'(rand_bits(20)), 5'd6, auipc));
    end
  endtask

  task automatic test_branches();
    logic [31:0] a;
    logic [31:0] b;
    for (int p = 0; p < branch_pairs; p++) begin
      a = rand_bits(32);
      case (p)
        0: b = a;
        1: begin
          a[31] = 1'b1;  // negative against positive.
          b     = {1'b0, 31'(rand_bits(31))};
        end
        2: begin
          a[31] = 1'b0;
          b     = {1'b1, 31'(rand_bits(31))};
        end
        default: b = rand_bits(32);
      endcase
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) issue(b_type({11'(rand_bits(11)), 2'b00}, 5'd2, 5'd1, 3'(f)));
      end
    end
  endtask

  task automatic test_jumps();
    logic [31:0] base;
    issue(j_type({19'(rand_bits(19)), 2'b00}, 5'd7));
    base = {30'(rand_bits(30)), 2'b01};  // odd base makes an odd jalr sum.
    load_reg(5'd8, base);
    issue(i_type({10'(rand_bits(10)), 2'b00}, 5'd8, 3'b000, 5'd9, jalr));
  endtask

  task automatic test_x0_idle();
    logic [31:0] held_pc;
    issue(i_type(12'(rand_bits(12)) | 12'h001, 5'd0, 3'b000, 5'd0, op_imm));
    issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd10));
    held_pc = mpc;
    instr   = i_type(12'h123, 5'd0, 3'b000, 5'd1, op_imm);
    repeat (idle_cycles) begin
      #1;
      check_value("rd_wen", 32'd0, 32'(rd_wen));
      @(negedge clk);
    end
    check_value("pc", held_pc, pc);
    issue(r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd11));  // x1 must be unchanged.
  endtask

  initial begin
    int asrt_errors;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 16'(seed);
    errors      = 0;
    cycles      = 0;
    mpc         = '0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_noop();
    test_alu_ops();
    test_upper();
    test_branches();
    test_jumps();
    test_x0_idle();
    asrt_errors = riscv_core_inst.riscv_core_chk_inst.fail_count;
    $display("summary: %0d check errors, %0d assertion errors", errors, asrt_errors);
    if (errors == 0 && asrt_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/riscv_core_chk.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_core_chk (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             instr_valid,
  input logic [riscv_pkg::data_width-1:0] pc,
  input logic                             rd_wen
);

  int fail_count = 0;

  reset_pc: assert property (@(posedge clk) !rst_n |=> pc == '0)
    else begin
      fail_count++;
      $error("pc is not zero in the cycle after reset");
    end

  // an idle cycle retires nothing, so pc must hold across it.
  idle_pc_hold: assert property (@(posedge clk) disable iff (!rst_n) !instr_valid |=> $stable(pc))
    else begin
      fail_count++;
      $error("pc changed while instr_valid was low");
    end

  // all targets driven by the testbench are word aligned.
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("pc lost word alignment");
    end

endmodule

`default_nettype wire

//--- src/riscv_core.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_core (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 instr_valid,
  input  logic [riscv_pkg::data_width-1:0]     instr,
  output logic [riscv_pkg::data_width-1:0]     pc,
  output logic                                 rd_wen,
  output logic [riscv_pkg::reg_addr_width-1:0] rd_addr,
  output logic [riscv_pkg::data_width-1:0]     rd_data
);
  import riscv_pkg::*;

  logic [reg_addr_width-1:0] rs1_addr;
  logic [reg_addr_width-1:0] rs2_addr;
  logic [data_width-1:0]     imm;
  alu_op_e                   alu_op;
  src_sel_e                  src_sel;
  logic                      is_branch;
  logic                      jump;
  logic                      jalr;
  logic                      reg_wen;
  logic [2:0]                funct3;
  logic [data_width-1:0]     src1;
  logic [data_width-1:0]     src2;
  logic [data_width-1:0]     exu_result;
  logic                      branch_taken;

  // ####################################################################
  // decode and operand fetch
  // ####################################################################

  riscv_idu riscv_idu_inst (
    .instr     (instr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .imm       (imm),
    .alu_op    (alu_op),
    .src_sel   (src_sel),
    .is_branch (is_branch),
    .jump      (jump),
    .jalr      (jalr),
    .reg_wen   (reg_wen),
    .funct3    (funct3)
  );

  assign rd_wen  = reg_wen && instr_valid;  // retire strobe for this cycle.
  assign rd_data = exu_result;

  riscv_regfile riscv_regfile_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (rd_wen),
    .waddr  (rd_addr),
    .wdata  (exu_result),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .rdata1 (src1),
    .rdata2 (src2)
  );

  // ####################################################################
  // execute and next pc
  // ####################################################################

  riscv_exu riscv_exu_inst (
    .pc           (pc),
    .src1         (src1),
    .src2         (src2),
    .imm          (imm),
    .is_branch    (is_branch),
    .alu_op       (alu_op),
    .src_sel      (src_sel),
    .funct3       (funct3),
    .branch_taken (branch_taken),
    .exu_result   (exu_result)
  );

  riscv_pcu riscv_pcu_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .jump         (jump),
    .jalr         (jalr),
    .branch_taken (branch_taken),
    .imm          (imm),
    .src1         (src1),
    .pc           (pc)
  );

endmodule

`default_nettype wire

//--- src/riscv_pcu.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_pcu (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             instr_valid,
  input  logic                             jump,
  input  logic                             jalr,
  input  logic                             branch_taken,
  input  logic [riscv_pkg::data_width-1:0] imm,
  input  logic [riscv_pkg::data_width-1:0] src1,
  output logic [riscv_pkg::data_width-1:0] pc
);
  import riscv_pkg::*;

  logic [data_width-1:0] jalr_target;
  logic [data_width-1:0] next_pc;

  assign jalr_target = src1 + imm;

  always_comb begin
    if (jalr) begin
      next_pc = {jalr_target[data_width-1:1], 1'b0};  // bit 0 is dropped.
    end else if (jump || branch_taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc + data_width'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (instr_valid) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- src/riscv_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_regfile (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 we,
  input  logic [riscv_pkg::reg_addr_width-1:0] waddr,
  input  logic [riscv_pkg::data_width-1:0]     wdata,
  input  logic [riscv_pkg::reg_addr_width-1:0] raddr1,
  input  logic [riscv_pkg::reg_addr_width-1:0] raddr2,
  output logic [riscv_pkg::data_width-1:0]     rdata1,
  output logic [riscv_pkg::data_width-1:0]     rdata2
);
  import riscv_pkg::*;

  // x0 has no storage.
  logic [data_width-1:0] regs [31:1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- src/riscv_idu.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_idu (
  input  logic [riscv_pkg::data_width-1:0]     instr,
  output logic [riscv_pkg::reg_addr_width-1:0] rs1_addr,
  output logic [riscv_pkg::reg_addr_width-1:0] rs2_addr,
  output logic [riscv_pkg::reg_addr_width-1:0] rd_addr,
  output logic [riscv_pkg::data_width-1:0]     imm,
  output riscv_pkg::alu_op_e                   alu_op,
  output riscv_pkg::src_sel_e                  src_sel,
  output logic                                 is_branch,
  output logic                                 jump,
  output logic                                 jalr,
  output logic                                 reg_wen,
  output logic [2:0]                           funct3
);
  import riscv_pkg::*;

  opcode_e               opcode;
  logic [data_width-1:0] imm_i;
  logic [data_width-1:0] imm_b;
  logic [data_width-1:0] imm_u;
  logic [data_width-1:0] imm_j;
  alu_op_e               arith_op;

  assign opcode   = opcode_e'(instr[6:0]);
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];
  assign funct3   = instr[14:12];

  // ####################################################################
  // immediates
  // ####################################################################

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // bit 30 picks sub only for register ops, sra for both forms.
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (instr[30] && opcode == op) ? sub : add;
      3'b001:  arith_op = sll;
      3'b010:  arith_op = slt;
      3'b011:  arith_op = sltu;
      3'b100:  arith_op = xor_op;
      3'b101:  arith_op = instr[30] ? sra : srl;
      3'b110:  arith_op = or_op;
      default: arith_op = and_op;
    endcase
  end

  // ####################################################################
  // control
  // ####################################################################

  always_comb begin
    imm       = imm_i;
    alu_op    = add;
    src_sel   = sel_rs1_rs2;
    is_branch = 1'b0;
    jump      = 1'b0;
    jalr      = 1'b0;
    reg_wen   = 1'b0;  // unknown words fall through as a no-op.
    case (opcode)
      op: begin
        alu_op  = arith_op;
        reg_wen = 1'b1;
      end
      op_imm: begin
        alu_op  = arith_op;
        src_sel = sel_rs1_imm;
        reg_wen = 1'b1;
      end
      lui: begin
        imm     = imm_u;
        alu_op  = pass_b;
        src_sel = sel_rs1_imm;
        reg_wen = 1'b1;
      end
      auipc: begin
        imm     = imm_u;
        src_sel = sel_pc_imm;
        reg_wen = 1'b1;
      end
      jal: begin
        imm     = imm_j;
        src_sel = sel_pc_4;  // link value is pc + 4.
        jump    = 1'b1;
        reg_wen = 1'b1;
      end
      riscv_pkg::jalr: begin
        src_sel = sel_pc_4;
        jump    = 1'b1;
        jalr    = 1'b1;
        reg_wen = 1'b1;
      end
      branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        case (funct3[2:1])
          2'b10:   alu_op = slt;
          2'b11:   alu_op = sltu;
          default: alu_op = sub;  // beq and bne compare against zero.
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/riscv_exu.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_exu (
  input  logic [riscv_pkg::data_width-1:0] pc,
  input  logic [riscv_pkg::data_width-1:0] src1,
  input  logic [riscv_pkg::data_width-1:0] src2,
  input  logic [riscv_pkg::data_width-1:0] imm,
  input  logic                             is_branch,
  input  riscv_pkg::alu_op_e               alu_op,
  input  riscv_pkg::src_sel_e              src_sel,
  input  logic [2:0]                       funct3,
  output logic                             branch_taken,
  output logic [riscv_pkg::data_width-1:0] exu_result
);
  import riscv_pkg::*;

  logic [data_width-1:0] alu_a_data;
  logic [data_width-1:0] alu_b_data;
  logic [data_width-1:0] alu_out_data;
  logic                  result_zero;

  always_comb begin
    case (src_sel)
      sel_rs1_rs2: {alu_a_data, alu_b_data} = {src1, src2};
      sel_rs1_imm: {alu_a_data, alu_b_data} = {src1, imm};
      sel_pc_4:    {alu_a_data, alu_b_data} = {pc, data_width'(4)};
      default:     {alu_a_data, alu_b_data} = {pc, imm};
    endcase
  end

  riscv_ex_alu riscv_ex_alu_inst (
    .alu_op       (alu_op),
    .alu_a_data   (alu_a_data),
    .alu_b_data   (alu_b_data),
    .alu_out_data (alu_out_data)
  );

  assign result_zero = (alu_out_data == '0);
  assign exu_result  = alu_out_data;

  // slt and sltu leave 0 or 1, so bit 0 carries the comparison.
  always_comb begin
    branch_taken = 1'b0;
    if (is_branch) begin
      case (funct3)
        3'b000, 3'b101, 3'b111: branch_taken = result_zero;
        3'b001:                 branch_taken = !result_zero;
        3'b100, 3'b110:         branch_taken = alu_out_data[0];
        default:                branch_taken = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/riscv_ex_alu.sv
`default_nettype none
`timescale 1ns/10ps

module riscv_ex_alu (
  input  riscv_pkg::alu_op_e               alu_op,
  input  logic [riscv_pkg::data_width-1:0] alu_a_data,
  input  logic [riscv_pkg::data_width-1:0] alu_b_data,
  output logic [riscv_pkg::data_width-1:0] alu_out_data
);
  import riscv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = alu_b_data[4:0];
  assign lt_signed   = $signed(alu_a_data) < $signed(alu_b_data);
  assign lt_unsigned = alu_a_data < alu_b_data;

  always_comb begin
    case (alu_op)
      add:     alu_out_data = alu_a_data + alu_b_data;
      sub:     alu_out_data = alu_a_data - alu_b_data;
      sll:     alu_out_data = alu_a_data << shamt;
      slt:     alu_out_data = {{(data_width-1){1'b0}}, lt_signed};
      sltu:    alu_out_data = {{(data_width-1){1'b0}}, lt_unsigned};
      xor_op:  alu_out_data = alu_a_data ^ alu_b_data;
      srl:     alu_out_data = alu_a_data >> shamt;
      sra:     alu_out_data = $unsigned($signed(alu_a_data) >>> shamt);
      or_op:   alu_out_data = alu_a_data | alu_b_data;
      and_op:  alu_out_data = alu_a_data & alu_b_data;
      pass_b:  alu_out_data = alu_b_data;
      default: alu_out_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  // ####################################################################
  // datapath widths, fixed at rv32.
  // ####################################################################

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  // major opcodes of the kept instruction classes.
  typedef enum logic [6:0] {
    op     = 7'b0110011,
    op_imm = 7'b0010011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    branch = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    sll    = 4'd2,
    slt    = 4'd3,
    sltu   = 4'd4,
    xor_op = 4'd5,
    srl    = 4'd6,
    sra    = 4'd7,
    or_op  = 4'd8,
    and_op = 4'd9,
    pass_b = 4'd10  // forwards operand b, used by lui.
  } alu_op_e;

  // operand pair that feeds the alu.
  typedef enum logic [1:0] {
    sel_rs1_rs2 = 2'd0,
    sel_rs1_imm = 2'd1,
    sel_pc_4    = 2'd2,
    sel_pc_imm  = 2'd3
  } src_sel_e;

endpackage

`default_nettype wire
